// File: project.f
+incdir+verilog
verilog/btb_pkg.sv
verilog/branch_target_buffer.sv
verilog/fetch_pc_stage.sv
verilog/fetch_out_stage.sv
verilog/branch_resolve_port.sv
verilog/branch_predict_top.sv
tests/tb_clock_gen.sv
tests/branch_predict_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module branch_predict_tb -o sim_branch_predict

./obj_dir/sim_branch_predict | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// File: tests/branch_predict_tb.sv
`timescale 1ns/1ps
`include "btb_defs.svh"

module branch_predict_tb;
    import btb_pkg::*;

    localparam int          TIMEOUT = 300;                  // Cycles allowed per wait
    localparam logic [31:0] SEED    = 32'hfd47_6039;
    localparam addr_t       P       = 32'h4000_0100;        // Branch for the hit and retarget checks
    localparam addr_t       T       = 32'h2000_0000;
    localparam addr_t       T2      = 32'h2800_0000;

    logic         clk;
    logic         reset;
    logic         resolve_req;
    resolve_rec_t resolve_rec;
    logic         out_ready;
    logic         resolve_ack;
    logic         out_valid;
    fetch_rec_t   out_rec;
    logic         alloc;

    // Reference copy of the buffer
    logic  m_valid [`BTB_ENTRIES];
    addr_t m_pc    [`BTB_ENTRIES];
    addr_t m_tgt   [`BTB_ENTRIES];
    int    m_ptr;

    logic [31:0] lfsr;
    logic        hold_ready_low;
    logic        redirect_pending;
    addr_t       redirect_pc_exp;
    fetch_rec_t  redirect_rec;          // First record after the latest redirect
    fetch_rec_t  held_rec;
    logic        held_valid;
    logic        ack_prev;
    addr_t       expected_pc;           // Next pc the chain rule allows
    addr_t       last_pc;
    int          xfer_count;

    tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    branch_predict_top u_branch_predict_top (
        .clk         (clk),
        .reset       (reset),
        .resolve_req (resolve_req),
        .resolve_rec (resolve_rec),
        .out_ready   (out_ready),
        .resolve_ack (resolve_ack),
        .out_valid   (out_valid),
        .out_rec     (out_rec),
        .alloc       (alloc)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int model_find(input addr_t pc);
        int idx;
        idx = -1;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            if (m_valid[i] && m_pc[i] == pc) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic model_write(input addr_t pc, input addr_t target);
        int idx;
        idx = model_find(pc);
        if (idx >= 0) begin
            m_tgt[idx] = target;            // Known branch gets a new target
        end else begin
            m_valid[m_ptr] = 1'b1;
            m_pc[m_ptr]    = pc;
            m_tgt[m_ptr]   = target;
            m_ptr          = (m_ptr + 1) % `BTB_ENTRIES;
        end
    endtask

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic value_error(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        fail_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
    endtask

    // Stimulus reads one time unit after the monitor has sampled
    task automatic next_sample();
        @(negedge clk);
        #1;
    endtask

    task automatic wait_cycle(inout int n, input string what);
        next_sample();
        n++;
        if (n > TIMEOUT) begin
            fail_run($sformatf("Timed out waiting for %s", what));
        end
    endtask

    task automatic send_resolve(input addr_t br_pc, input logic br_taken,
                                input addr_t br_target, input addr_t br_pred);
        addr_t actual;
        logic  exp_alloc;
        int    n;
        actual    = br_taken ? br_target : br_pc + addr_t'(`INSN_BYTES);
        exp_alloc = br_taken && (model_find(br_pc) < 0);
        @(posedge clk);
        #2;
        if (br_pred != actual) begin
            redirect_pc_exp  = actual;      // Fetch must restart here
            redirect_pending = 1'b1;
        end
        resolve_rec.pc        = br_pc;
        resolve_rec.taken     = br_taken;
        resolve_rec.target    = br_target;
        resolve_rec.pred_next = br_pred;
        resolve_req           = 1'b1;
        n = 0;
        while (!resolve_ack) wait_cycle(n, "resolve_ack to rise");
        @(posedge clk);
        #2;
        resolve_req = 1'b0;
        next_sample();                      // Alloc follows the update by one edge
        assert (alloc == exp_alloc) else value_error("alloc", 96'(alloc), 96'(exp_alloc));
        n = 0;
        while (resolve_ack) wait_cycle(n, "resolve_ack to fall");
        if (br_taken) begin
            model_write(br_pc, br_target);
        end
        n = 0;
        while (redirect_pending) wait_cycle(n, "the redirected fetch record");
    endtask

    // Not-taken branch just before pc with a wrong prediction sends fetch to pc
    task automatic steer_to(input addr_t pc);
        send_resolve(pc - addr_t'(`INSN_BYTES), 1'b0, '0, pc + addr_t'(`INSN_BYTES));
    endtask

    function automatic addr_t branch_pc(input int i);
        return addr_t'(32'h4000_1000 + i * 32'h100);
    endfunction

    function automatic addr_t branch_target(input int i);
        return addr_t'(32'h3000_0000 + i * 32'h10_0000);
    endfunction

    // out_ready follows one LFSR bit per cycle unless held low
    always @(posedge clk) begin
        #2;
        if (hold_ready_low) begin
            out_ready = 1'b0;
        end else begin
            lfsr      = lfsr_step(lfsr);
            out_ready = lfsr[0];
        end
    end

    always @(negedge clk) begin
        int    idx;
        addr_t exp_next;
        if (reset) begin
            if (resolve_ack && !ack_prev) begin
                assert (resolve_req) else fail_run("resolve_ack rose while resolve_req was low");
            end
            if (!resolve_ack && ack_prev) begin
                assert (!resolve_req) else fail_run("resolve_ack fell while resolve_req was high");
            end
            if (held_valid && out_valid) begin
                assert (out_rec == held_rec)
                    else value_error("out_rec", 96'(out_rec), 96'(held_rec));
            end
            if (out_valid && out_ready) begin
                if (redirect_pending && out_rec.pc == redirect_pc_exp) begin
                    redirect_pending = 1'b0;
                    expected_pc      = redirect_pc_exp;   // Chain restarts here
                    redirect_rec     = out_rec;
                end
                idx      = model_find(out_rec.pc);
                exp_next = (idx >= 0) ? m_tgt[idx] : out_rec.pc + addr_t'(`INSN_BYTES);
                assert (out_rec.pc == expected_pc)
                    else value_error("out_rec.pc", 96'(out_rec.pc), 96'(expected_pc));
                assert (out_rec.hit == (idx >= 0))
                    else value_error("out_rec.hit", 96'(out_rec.hit), 96'(idx >= 0));
                assert (out_rec.pred_next == exp_next)
                    else value_error("out_rec.pred_next", 96'(out_rec.pred_next), 96'(exp_next));
                expected_pc = out_rec.pred_next;
                last_pc     = out_rec.pc;
                xfer_count++;
            end
            held_valid = out_valid && !out_ready;
            held_rec   = out_rec;
            ack_prev   = resolve_ack;
        end
    end

    initial begin
        int n;
        int n0;
        resolve_req      = 1'b0;
        resolve_rec      = '0;
        out_ready        = 1'b0;
        lfsr             = SEED;
        hold_ready_low   = 1'b0;
        redirect_pending = 1'b0;
        held_valid       = 1'b0;
        ack_prev         = 1'b0;
        expected_pc      = `RESET_PC;
        xfer_count       = 0;
        m_ptr            = 0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        n = 0;
        while (!reset) wait_cycle(n, "reset release");
        assert (!resolve_ack) else value_error("resolve_ack", 96'(resolve_ack), 96'(0));
        n = 0;
        while (xfer_count < 12) wait_cycle(n, "the first fetch records");

        hold_ready_low = 1'b1;                      // Back-pressure
        n = 0;
        while (!out_valid) wait_cycle(n, "out_valid under back-pressure");
        repeat (6) next_sample();
        assert (out_valid) else fail_run("Held record was lost under back-pressure");
        hold_ready_low = 1'b0;

        send_resolve(P, 1'b1, T, P + addr_t'(`INSN_BYTES));
        steer_to(P);
        assert (redirect_rec.hit) else value_error("out_rec.hit", 96'(redirect_rec.hit), 96'(1));
        assert (redirect_rec.pred_next == T)
            else value_error("out_rec.pred_next", 96'(redirect_rec.pred_next), 96'(T));
        n0 = xfer_count;
        n  = 0;
        while (xfer_count == n0) wait_cycle(n, "the record after the predicted branch");
        assert (last_pc == T) else value_error("out_rec.pc", 96'(last_pc), 96'(T));

        send_resolve(P, 1'b1, T2, P + addr_t'(`INSN_BYTES));     // Retarget without allocation
        steer_to(P);
        assert (redirect_rec.pred_next == T2)
            else value_error("out_rec.pred_next", 96'(redirect_rec.pred_next), 96'(T2));

        for (int i = 0; i < 9; i++) begin
            send_resolve(branch_pc(i), 1'b1, branch_target(i),
                         branch_pc(i) + addr_t'(`INSN_BYTES));
        end
        steer_to(branch_pc(0));                     // Replaced by the ninth
        assert (!redirect_rec.hit)
            else value_error("out_rec.hit", 96'(redirect_rec.hit), 96'(0));
        steer_to(branch_pc(8));
        assert (redirect_rec.pred_next == branch_target(8))
            else value_error("out_rec.pred_next", 96'(redirect_rec.pred_next),
                             96'(branch_target(8)));

        $display("All checks passed");
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b0;               // Active low, held from time zero
        repeat (8) @(posedge clk);
        #2 reset = 1'b1;
    end

    always #20 clk = ~clk;          // 40 ns period

endmodule

// File: verilog/branch_predict_top.sv
`timescale 1ns/1ps

module branch_predict_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  resolve_req,
    input  btb_pkg::resolve_rec_t resolve_rec,
    input  logic                  out_ready,
    output logic                  resolve_ack,
    output logic                  out_valid,
    output btb_pkg::fetch_rec_t   out_rec,
    output logic                  alloc
);
    import btb_pkg::*;

    addr_t       lookup_pc;
    addr_t       lookup_target;
    logic        lookup_hit;
    logic        can_accept;
    logic        push;
    fetch_rec_t  pc_rec;
    logic        redirect;
    addr_t       redirect_pc;
    btb_update_t btb_update;

    fetch_pc_stage u_pc_stage (
        .clk           (clk),
        .reset         (reset),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target),
        .can_accept    (can_accept),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .lookup_pc     (lookup_pc),
        .push          (push),
        .rec           (pc_rec)
    );

    branch_target_buffer u_btb (
        .clk           (clk),
        .reset         (reset),
        .lookup_pc     (lookup_pc),
        .update        (btb_update),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target),
        .alloc         (alloc)
    );

    // Flush shares the redirect pulse
    fetch_out_stage u_out_stage (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .rec_in     (pc_rec),
        .flush      (redirect),
        .out_ready  (out_ready),
        .can_accept (can_accept),
        .out_valid  (out_valid),
        .out_rec    (out_rec)
    );

    branch_resolve_port u_resolve (
        .clk         (clk),
        .reset       (reset),
        .resolve_req (resolve_req),
        .resolve_rec (resolve_rec),
        .resolve_ack (resolve_ack),
        .btb_update  (btb_update),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: verilog/branch_resolve_port.sv
`timescale 1ns/1ps
`include "btb_defs.svh"

module branch_resolve_port (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  resolve_req,
    input  btb_pkg::resolve_rec_t resolve_rec,
    output logic                  resolve_ack,
    output btb_pkg::btb_update_t  btb_update,
    output logic                  redirect,
    output btb_pkg::addr_t        redirect_pc
);
    import btb_pkg::*;

    typedef enum logic [1:0] {
        idle,
        capture,
        ack_high,
        wait_low
    } state_t;

    state_t       state_q;
    resolve_rec_t rec_q;
    addr_t        actual_next;
    logic         mispredict;
    logic         upd_valid_q;

    // Where execution really continues after the branch
    assign actual_next = rec_q.taken ? rec_q.target : rec_q.pc + addr_t'(`INSN_BYTES);
    assign mispredict  = (rec_q.pred_next != actual_next);
    assign redirect_pc = actual_next;

    always_comb begin
        btb_update.valid  = upd_valid_q;
        btb_update.pc     = rec_q.pc;
        btb_update.target = rec_q.target;
    end

    // Ack is high in ack_high and through wait_low
    assign resolve_ack = (state_q == ack_high) || (state_q == wait_low);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q     <= idle;
            upd_valid_q <= 1'b0;
            redirect    <= 1'b0;
        end else begin
            // Pulses last one cycle, the first one with ack high
            upd_valid_q <= (state_q == capture) && rec_q.taken;
            redirect    <= (state_q == capture) && mispredict;
            case (state_q)
                idle:     if (resolve_req) state_q <= capture;
                capture:  state_q <= ack_high;
                ack_high: if (!resolve_req) state_q <= wait_low;
                wait_low: state_q <= idle;
                default:  state_q <= idle;
            endcase
        end
    end

    // Record is stable while req is high
    always_ff @(posedge clk) begin
        if (state_q == idle && resolve_req) begin
            rec_q <= resolve_rec;
        end
    end

    assert property (@(posedge clk) disable iff (!reset)
        $rose(resolve_ack) |-> $past(resolve_req));

endmodule

// File: verilog/fetch_out_stage.sv
`timescale 1ns/1ps

module fetch_out_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  btb_pkg::fetch_rec_t rec_in,
    input  logic                flush,
    input  logic                out_ready,
    output logic                can_accept,
    output logic                out_valid,
    output btb_pkg::fetch_rec_t out_rec
);

    // Room if empty or the current record leaves this cycle
    assign can_accept = !out_valid || out_ready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;      // Drop the wrong-path record
        end else if (push) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only moves on push, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (push) begin
            out_rec <= rec_in;
        end
    end

endmodule

// File: verilog/fetch_pc_stage.sv
`timescale 1ns/1ps
`include "btb_defs.svh"

module fetch_pc_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                lookup_hit,
    input  btb_pkg::addr_t      lookup_target,
    input  logic                can_accept,
    input  logic                redirect,
    input  btb_pkg::addr_t      redirect_pc,
    output btb_pkg::addr_t      lookup_pc,
    output logic                push,
    output btb_pkg::fetch_rec_t rec
);
    import btb_pkg::*;

    addr_t pc_q;
    addr_t next_pc;

    assign lookup_pc = pc_q;

    // Predicted target, else fall-through
    assign next_pc = lookup_hit ? lookup_target : pc_q + addr_t'(`INSN_BYTES);

    // Redirected PC is pushed one edge later
    assign push = !redirect && can_accept;

    always_comb begin
        rec.pc        = pc_q;
        rec.pred_next = next_pc;
        rec.hit       = lookup_hit;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= `RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;    // Execute overrides prediction
        end else if (can_accept) begin
            pc_q <= next_pc;
        end
        // Stall otherwise, PC holds
    end

endmodule

// File: verilog/branch_target_buffer.sv
`timescale 1ns/1ps
`include "btb_defs.svh"

module branch_target_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  btb_pkg::addr_t       lookup_pc,
    input  btb_pkg::btb_update_t update,
    output logic                 lookup_hit,
    output btb_pkg::addr_t       lookup_target,
    output logic                 alloc
);
    import btb_pkg::*;

    logic     valid_q [`BTB_ENTRIES];
    addr_t    pc_q    [`BTB_ENTRIES];
    addr_t    tgt_q   [`BTB_ENTRIES];
    btb_idx_t ptr_q;                     // Next entry to replace

    logic [`BTB_ENTRIES-1:0] lookup_match;
    logic [`BTB_ENTRIES-1:0] update_match;
    btb_idx_t                hit_idx;
    btb_idx_t                upd_idx;
    logic                    upd_hit;

    // Lookup where the lowest matching entry wins
    always_comb begin
        lookup_hit = 1'b0;
        hit_idx    = '0;
        for (int i = `BTB_ENTRIES - 1; i >= 0; i--) begin
            lookup_match[i] = valid_q[i] && (pc_q[i] == lookup_pc);
            if (lookup_match[i]) begin
                lookup_hit = 1'b1;
                hit_idx    = btb_idx_t'(i);
            end
        end
        lookup_target = lookup_hit ? tgt_q[hit_idx] : '0;
    end

    // Separate match for the write port
    always_comb begin
        upd_hit = 1'b0;
        upd_idx = '0;
        for (int i = `BTB_ENTRIES - 1; i >= 0; i--) begin
            update_match[i] = valid_q[i] && (pc_q[i] == update.pc);
            if (update_match[i]) begin
                upd_hit = 1'b1;
                upd_idx = btb_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
            ptr_q <= '0;
            alloc <= 1'b0;
        end else begin
            alloc <= update.valid && !upd_hit;
            if (update.valid && !upd_hit) begin
                valid_q[ptr_q] <= 1'b1;
                // Round-robin wrap
                if (ptr_q == btb_idx_t'(`BTB_ENTRIES - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= ptr_q + 1'b1;
                end
            end
        end
    end

    // Entry contents
    always_ff @(posedge clk) begin
        if (update.valid) begin
            if (upd_hit) begin
                tgt_q[upd_idx] <= update.target;   // Retarget existing entry
            end else begin
                pc_q[ptr_q]  <= update.pc;
                tgt_q[ptr_q] <= update.target;
            end
        end
    end

    // A PC is never stored twice
    assert property (@(posedge clk) disable iff (!reset)
        $onehot0(lookup_match) && $onehot0(update_match));

    // Allocation follows an update and fills the entry the pointer named
    assert property (@(posedge clk) disable iff (!reset)
        alloc |-> $past(update.valid) && valid_q[$past(ptr_q)]
                  && (pc_q[$past(ptr_q)] == $past(update.pc)));

endmodule

// File: verilog/btb_pkg.sv
`include "btb_defs.svh"

package btb_pkg;

    // PC or branch target
    typedef logic [`ADDR_W-1:0] addr_t;

    // Buffer entry index
    typedef logic [$clog2(`BTB_ENTRIES)-1:0] btb_idx_t;

    // One fetched instruction with its prediction
    typedef struct packed {
        addr_t pc;
        addr_t pred_next;   // PC fetched after this one
        logic  hit;         // Buffer supplied pred_next
    } fetch_rec_t;

    // Resolved branch reported by execute
    typedef struct packed {
        addr_t pc;
        logic  taken;
        addr_t target;
        addr_t pred_next;   // Next PC the front end used
    } resolve_rec_t;

    // Write request into the buffer
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t target;
    } btb_update_t;

endpackage

// File: verilog/btb_defs.svh
`ifndef BTB_DEFS_SVH
`define BTB_DEFS_SVH

// Branch target buffer geometry
`define BTB_ENTRIES 8

// PC and target width in bits
`define ADDR_W 32

// Fall-through step, one instruction
`define INSN_BYTES 4

// First PC fetched after reset
`define RESET_PC 32'h0000_1000

`endif
